// File: logic/lvdcPkg.sv
package lvdcPkg;

    localparam int syllableBits = 13;
    localparam int addrBits     = 8;
    localparam int selBits      = 4;
    localparam int selLines     = 16;
    localparam int bitTimes     = 14;
    localparam int cntBits      = $clog2(bitTimes + 1);

    // a stored word is the 13 data bits with the parity bit below them.
    typedef struct packed {
        logic [syllableBits-1:0] data;
        logic                    parity;
    } syllable_t;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOp_t;

    typedef struct packed {
        memOp_t              op;
        logic [addrBits-1:0] addr;
    } memCmd_t;

    typedef struct packed {
        logic latchAddr;
        logic shiftIn;
        logic memWrite;
        logic memRead;
        logic loadXfer;
        logic shiftOut;
    } memCtl_t;

    // returns the bit that gives data plus parity an odd count of ones.
    function automatic logic oddParity(input logic [syllableBits-1:0] data);
        return ~(^data);
    endfunction

endpackage

// File: logic/memTiming.sv
`timescale 1ns/10ps

module memTiming import lvdcPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cmdStrobe,
    input  memCmd_t cmd,
    output memCtl_t ctl,
    output logic    busy,
    output logic    done,
    output logic    doutValid
);

    logic [cntBits-1:0] bitCnt;
    logic [cntBits-1:0] nextCnt;
    memOp_t             opQ;
    memOp_t             nextOp;
    logic               nextBusy;
    logic               accept;
    logic               finish;
    logic               isStore;
    logic               isLoad;
    logic               nextValid;
    memCtl_t            nextCtl;

    assign accept = cmdStrobe && !busy;
    assign finish = busy && (bitCnt == cntBits'(bitTimes - 1));

    // bitCnt holds the number of the last edge, counted from the accepting edge.
    always_comb begin
        nextCnt  = bitCnt;
        nextBusy = busy;
        nextOp   = opQ;
        if (accept) begin
            nextCnt  = '0;
            nextBusy = 1'b1;
            nextOp   = cmd.op;
        end else if (busy) begin
            nextCnt  = bitCnt + 1'b1;
            nextBusy = !finish;
        end
    end

    assign isStore = nextBusy && (nextOp == opStore);
    assign isLoad  = nextBusy && (nextOp == opLoad);

    // the address latch stays open while idle, so it closes on the very edge
    // that accepts the strobe and the selects are settled for a read at edge 1.
    always_comb begin
        nextCtl.latchAddr = !nextBusy;
        nextCtl.shiftIn   = isStore && (nextCnt <= cntBits'(syllableBits - 1));
        nextCtl.memWrite  = isStore && (nextCnt == cntBits'(bitTimes - 1));
        nextCtl.memRead   = isLoad && (nextCnt == cntBits'(0));
        nextCtl.loadXfer  = isLoad && (nextCnt == cntBits'(1));
        nextCtl.shiftOut  = isLoad && (nextCnt >= cntBits'(2));
    end

    // the last serial bit is still valid in the cycle that carries done.
    assign nextValid = (nextOp == opLoad) && (nextBusy || finish)
                       && (nextCnt >= cntBits'(2));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitCnt    <= '0;
            opQ       <= opLoad;
            busy      <= 1'b0;
            done      <= 1'b0;
            doutValid <= 1'b0;
            ctl       <= '0;
        end else begin
            bitCnt    <= nextCnt;
            opQ       <= nextOp;
            busy      <= nextBusy;
            done      <= finish;
            doutValid <= nextValid;
            ctl       <= nextCtl;
        end
    end

endmodule

// File: logic/addrDecode.sv
`timescale 1ns/10ps

module addrDecode import lvdcPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  memCtl_t             ctl,
    input  logic [addrBits-1:0] addr,
    output logic [selLines-1:0] xSel,
    output logic [selLines-1:0] ySel
);

    logic [addrBits-1:0] addrQ;
    logic [selBits-1:0]  xAddr;
    logic [selBits-1:0]  yAddr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrQ <= '0;
        end else if (ctl.latchAddr) begin
            addrQ <= addr;
        end
    end

    assign xAddr = addrQ[selBits-1:0];
    assign yAddr = addrQ[addrBits-1:selBits];

    // one drive line per axis, like the core drivers of the X and Y matrix.
    always_comb begin
        xSel = '0;
        ySel = '0;
        for (int i = 0; i < selLines; i++) begin
            if (xAddr == selBits'(i)) begin
                xSel[i] = 1'b1;
            end
            if (yAddr == selBits'(i)) begin
                ySel[i] = 1'b1;
            end
        end
    end

endmodule

// File: logic/coreMemory.sv
`timescale 1ns/10ps

module coreMemory import lvdcPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  memCtl_t             ctl,
    input  logic [selLines-1:0] xSel,
    input  logic [selLines-1:0] ySel,
    input  syllable_t           wrSyl,
    output syllable_t           rdSyl
);

    syllable_t coreArray [selLines][selLines];

    // a word is selected only where a driven X line crosses a driven Y line.
    always_comb begin
        rdSyl = '0;
        for (int y = 0; y < selLines; y++) begin
            for (int x = 0; x < selLines; x++) begin
                if (ySel[y] && xSel[x]) begin
                    rdSyl = coreArray[y][x];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int y = 0; y < selLines; y++) begin
                for (int x = 0; x < selLines; x++) begin
                    coreArray[y][x] <= '0;
                end
            end
        end else if (ctl.memWrite) begin
            for (int y = 0; y < selLines; y++) begin
                for (int x = 0; x < selLines; x++) begin
                    if (ySel[y] && xSel[x]) begin
                        coreArray[y][x] <= wrSyl;
                    end
                end
            end
        end
    end

endmodule

// File: logic/bufferReg.sv
`timescale 1ns/10ps

module bufferReg import lvdcPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  memCtl_t                 ctl,
    input  logic [syllableBits-1:0] xferData,
    input  syllable_t               rdSyl,
    output syllable_t               wrSyl,
    output logic [syllableBits-1:0] bufData,
    output logic                    parErr
);

    logic [syllableBits-1:0] bufQ;
    logic                    rdBad;

    // the parity bit is generated on the way into the core.
    always_comb begin
        wrSyl.data   = xferData;
        wrSyl.parity = oddParity(xferData);
    end

    assign rdBad = (rdSyl.parity != oddParity(rdSyl.data));

    always_ff @(posedge clk) begin
        if (ctl.memRead) begin
            bufQ <= rdSyl.data;
        end
    end

    // the flag keeps the result of the last read until the next one.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            parErr <= 1'b0;
        end else if (ctl.memRead) begin
            parErr <= rdBad;
        end
    end

    assign bufData = bufQ;

endmodule

// File: logic/transferReg.sv
`timescale 1ns/10ps

module transferReg import lvdcPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  memCtl_t                 ctl,
    input  logic                    din,
    input  logic [syllableBits-1:0] bufData,
    output logic [syllableBits-1:0] xferData,
    output logic                    dout
);

    logic [syllableBits-1:0] shiftQ;
    logic                    shiftBit;
    logic                    doShift;

    // serial data moves toward bit 0, so the first bit in ends up at bit 0
    // and bit 0 is always the next bit out.
    assign shiftBit = ctl.shiftIn ? din : 1'b0;
    assign doShift  = ctl.shiftIn || ctl.shiftOut;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftQ <= '0;
        end else if (ctl.loadXfer) begin
            shiftQ <= bufData;
        end else if (doShift) begin
            shiftQ <= {shiftBit, shiftQ[syllableBits-1:1]};
        end
    end

    assign xferData = shiftQ;
    assign dout     = shiftQ[0];

endmodule

// File: logic/lvdcMem.sv
`timescale 1ns/10ps

module lvdcMem import lvdcPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    cmdStrobe,
    input  memCmd_t cmd,
    input  logic    din,
    output logic    dout,
    output logic    doutValid,
    output logic    busy,
    output logic    done,
    output logic    parErr
);

    memCtl_t                 ctl;
    logic [selLines-1:0]     xSel;
    logic [selLines-1:0]     ySel;
    logic [syllableBits-1:0] xferData;
    logic [syllableBits-1:0] bufData;
    syllable_t               wrSyl;
    syllable_t               rdSyl;

    memTiming uTiming (
        .clk       (clk),
        .rstN      (rstN),
        .cmdStrobe (cmdStrobe),
        .cmd       (cmd),
        .ctl       (ctl),
        .busy      (busy),
        .done      (done),
        .doutValid (doutValid)
    );

    addrDecode uDecode (
        .clk  (clk),
        .rstN (rstN),
        .ctl  (ctl),
        .addr (cmd.addr),
        .xSel (xSel),
        .ySel (ySel)
    );

    coreMemory uCore (
        .clk   (clk),
        .rstN  (rstN),
        .ctl   (ctl),
        .xSel  (xSel),
        .ySel  (ySel),
        .wrSyl (wrSyl),
        .rdSyl (rdSyl)
    );

    bufferReg uBuffer (
        .clk      (clk),
        .rstN     (rstN),
        .ctl      (ctl),
        .xferData (xferData),
        .rdSyl    (rdSyl),
        .wrSyl    (wrSyl),
        .bufData  (bufData),
        .parErr   (parErr)
    );

    transferReg uXfer (
        .clk      (clk),
        .rstN     (rstN),
        .ctl      (ctl),
        .din      (din),
        .bufData  (bufData),
        .xferData (xferData),
        .dout     (dout)
    );

endmodule

// File: sim/lvdcMem_sva.sv
`timescale 1ns/10ps

module lvdcMemSva import lvdcPkg::*; (
    input logic    clk,
    input logic    rstN,
    input memCtl_t ctl,
    input memOp_t  opQ,
    input logic    busy,
    input logic    done,
    input logic    doutValid
);

    int doneFails       = 0;
    int overlapFails    = 0;
    int storeValidFails = 0;

    donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else begin
            doneFails++;
            $error("done stayed high for more than one cycle");
        end

    // a write and a serial shift never share a bit time.
    writeShiftApart: assert property (@(posedge clk) disable iff (!rstN)
        !(ctl.memWrite && ctl.shiftOut))
        else begin
            overlapFails++;
            $error("memWrite and shiftOut high together");
        end

    noValidInStore: assert property (@(posedge clk) disable iff (!rstN)
        (busy && opQ == opStore) |-> !doutValid)
        else begin
            storeValidFails++;
            $error("doutValid high during a store");
        end

endmodule

bind memTiming lvdcMemSva uSva (
    .clk       (clk),
    .rstN      (rstN),
    .ctl       (ctl),
    .opQ       (opQ),
    .busy      (busy),
    .done      (done),
    .doutValid (doutValid)
);

// File: sim/lvdcMemTb.sv
`timescale 1ns/10ps

module lvdcMemTb import lvdcPkg::*; ();

    typedef struct packed {
        memOp_t                  op;
        logic [addrBits-1:0]     addr;
        logic [syllableBits-1:0] data;
        logic [syllableBits-1:0] expData;
        logic                    expErr;
        logic                    poke;
    } testEntry_t;

    logic                    clk;
    logic                    rstN;
    logic                    cmdStrobe;
    memCmd_t                 cmd;
    logic                    din;
    logic                    dout;
    logic                    doutValid;
    logic                    busy;
    logic                    done;
    logic                    parErr;
    testEntry_t              testTable [17];
    logic [syllableBits-1:0] modelData [2**addrBits];
    logic [addrBits-1:0]     storedAddrs [$];
    logic [31:0]             lcgState;
    int                      failCount;
    int                      testCount;
    logic                    aborted;

    lvdcMem uut (
        .clk       (clk),
        .rstN      (rstN),
        .cmdStrobe (cmdStrobe),
        .cmd       (cmd),
        .din       (din),
        .dout      (dout),
        .doutValid (doutValid),
        .busy      (busy),
        .done      (done),
        .parErr    (parErr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic testEntry_t entry(input memOp_t op, input logic [addrBits-1:0] addr,
                                         input logic [syllableBits-1:0] data,
                                         input logic [syllableBits-1:0] expData,
                                         input logic expErr, input logic poke);
        testEntry_t e;
        e.op      = op;
        e.addr    = addr;
        e.data    = data;
        e.expData = expData;
        e.expErr  = expErr;
        e.poke    = poke;
        return e;
    endfunction

    function automatic int boundAssertFails();
        return uut.uTiming.uSva.doneFails + uut.uTiming.uSva.overlapFails
               + uut.uTiming.uSva.storeValidFails;
    endfunction

    task automatic showMismatch(input int id, input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("MISMATCH test %0d %s: got %h expected %h", id, name, got, exp);
    endtask

    // unwritten words read back as zero with a parity error, since zero ones is even.
    task automatic fillTable();
        testTable[0]  = entry(opLoad,  8'h00, 13'h0000, 13'h0000, 1'b1, 1'b0);
        testTable[1]  = entry(opLoad,  8'h5a, 13'h0000, 13'h0000, 1'b1, 1'b0);
        testTable[2]  = entry(opStore, 8'h5a, 13'h1a5c, 13'h0000, 1'b0, 1'b0);
        testTable[3]  = entry(opLoad,  8'h5a, 13'h0000, 13'h1a5c, 1'b0, 1'b0);
        testTable[4]  = entry(opStore, 8'h03, 13'h0f0f, 13'h0000, 1'b0, 1'b0);
        testTable[5]  = entry(opStore, 8'h13, 13'h1234, 13'h0000, 1'b0, 1'b0);
        testTable[6]  = entry(opStore, 8'h14, 13'h0777, 13'h0000, 1'b0, 1'b0);
        testTable[7]  = entry(opLoad,  8'h03, 13'h0000, 13'h0f0f, 1'b0, 1'b0);
        testTable[8]  = entry(opLoad,  8'h13, 13'h0000, 13'h1234, 1'b0, 1'b0);
        testTable[9]  = entry(opLoad,  8'h14, 13'h0000, 13'h0777, 1'b0, 1'b0);
        testTable[10] = entry(opStore, 8'h13, 13'h1fff, 13'h0000, 1'b0, 1'b1);
        testTable[11] = entry(opLoad,  8'h13, 13'h0000, 13'h1fff, 1'b0, 1'b1);
        testTable[12] = entry(opLoad,  8'h03, 13'h0000, 13'h0f0f, 1'b0, 1'b0);
        testTable[13] = entry(opStore, 8'hff, 13'h0001, 13'h0000, 1'b0, 1'b0);
        testTable[14] = entry(opLoad,  8'hff, 13'h0000, 13'h0001, 1'b0, 1'b0);
        testTable[15] = entry(opStore, 8'h00, 13'h0000, 13'h0000, 1'b0, 1'b0);
        testTable[16] = entry(opLoad,  8'h00, 13'h0000, 13'h0000, 1'b0, 1'b0);
    endtask

    // one loop pass per cycle, sampling 2 ns after the edge and then driving.
    task automatic runTest(input testEntry_t t, input int id);
        logic [syllableBits-1:0] got;
        int                      n;
        int                      validCnt;
        int                      expValid;
        logic                    seenDone;
        logic                    busyOk;
        logic                    ok;
        got      = '0;
        n        = 0;
        validCnt = 0;
        seenDone = 1'b0;
        busyOk   = 1'b1;
        ok       = 1'b1;
        testCount++;
        cmd.op    = t.op;
        cmd.addr  = t.addr;
        cmdStrobe = 1'b1;
        @(posedge clk);
        #2;
        while (!seenDone && n < 40) begin
            if (doutValid) begin
                if (validCnt < syllableBits) begin
                    got[validCnt] = dout;
                end
                validCnt++;
            end
            if (done) begin
                seenDone = 1'b1;
            end else begin
                if (!busy) begin
                    busyOk = 1'b0;
                end
                din = (t.op == opStore && n < syllableBits) ? t.data[n] : 1'b0;
                // a second command in mid-transfer must be dropped.
                cmdStrobe = t.poke && (n == 4);
                cmd.op    = (t.op == opLoad) ? opStore : opLoad;
                cmd.addr  = t.addr ^ 8'hff;
                @(posedge clk);
                #2;
                n++;
            end
        end
        if (!seenDone) begin
            $display("test %0d: done did not arrive within 40 cycles of the strobe", id);
            failCount++;
            aborted = 1'b1;
            return;
        end
        if (n != bitTimes) begin
            showMismatch(id, "done latency", 32'(n + 1), 32'(bitTimes + 1));
            ok = 1'b0;
        end
        if (!busyOk || busy) begin
            $display("test %0d: busy was not high for the whole command", id);
            ok = 1'b0;
        end
        expValid = (t.op == opLoad) ? syllableBits : 0;
        if (validCnt != expValid) begin
            showMismatch(id, "doutValid count", 32'(validCnt), 32'(expValid));
            ok = 1'b0;
        end
        if (t.op == opLoad && got != t.expData) begin
            showMismatch(id, "dout data", 32'(got), 32'(t.expData));
            ok = 1'b0;
        end
        if (t.op == opLoad && parErr != t.expErr) begin
            showMismatch(id, "parErr", 32'(parErr), 32'(t.expErr));
            ok = 1'b0;
        end
        @(posedge clk);
        #2;
        if (busy || done || doutValid) begin
            $display("test %0d: busy, done or doutValid still high one cycle after done", id);
            ok = 1'b0;
        end
        if (!ok) begin
            failCount++;
        end
        $display("test %0d %s addr %h: %s", id, (t.op == opStore) ? "store" : "load ",
                 t.addr, ok ? "ok" : "error");
    endtask

    initial begin
        testEntry_t          e;
        logic [addrBits-1:0] addr;
        int                  pick;
        clk       = 1'b0;
        rstN      = 1'b0;
        cmdStrobe = 1'b0;
        cmd       = '0;
        din       = 1'b0;
        failCount = 0;
        testCount = 0;
        aborted   = 1'b0;
        lcgState  = 32'h157d_d801;
        fillTable();
        repeat (16) @(posedge clk);
        #2;
        if (busy || done || doutValid || parErr) begin
            $display("reset: an output is high while rstN is low");
            failCount++;
        end
        rstN = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < $size(testTable); i++) begin
            if (!aborted) begin
                runTest(testTable[i], testCount);
                if (testTable[i].op == opStore) begin
                    modelData[testTable[i].addr] = testTable[i].data;
                end
            end
        end
        // each random load reads back one of the words stored by the random stores.
        for (int r = 0; r < 20; r++) begin
            if (!aborted) begin
                lcgState = lcgNext(lcgState);
                addr     = lcgState[31:24];
                lcgState = lcgNext(lcgState);
                e        = entry(opStore, addr, lcgState[28:16], 13'h0000, 1'b0, 1'b0);
                runTest(e, testCount);
                modelData[addr] = e.data;
                storedAddrs.push_back(addr);
                lcgState = lcgNext(lcgState);
                pick     = int'(lcgState[23:16]) % storedAddrs.size();
                addr     = storedAddrs[pick];
                e        = entry(opLoad, addr, 13'h0000, modelData[addr], 1'b0, 1'b0);
                runTest(e, testCount);
            end
        end
        $display("tests run %0d, with errors %0d, assertion failures %0d",
                 testCount, failCount, boundAssertFails());
        if (failCount == 0 && boundAssertFails() == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/lvdcPkg.sv
logic/memTiming.sv
logic/addrDecode.sv
logic/coreMemory.sv
logic/bufferReg.sv
logic/transferReg.sv
logic/lvdcMem.sv
sim/lvdcMem_sva.sv
sim/lvdcMemTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module lvdcMemTb -f filelist.f
	out="$$(./obj_dir/VlvdcMemTb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "all tests passed"

clean:
	rm -rf obj_dir
